// File: bench/tb_memtest.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module tb_memtest;

    localparam int ROWS       = 5;
    localparam int PASS_REQS  = 1792;  // 512 burst wr, 256 rd, 256 scr wr, 256 rd, 512 alt
    localparam int PASS_READS = 768;

    logic clk      = 1'b0;
    logic rst_n    = 1'b0;
    logic calib    = 1'b0;
    logic btn      = 1'b0;
    logic wb_stall = 1'b0;
    logic                     wb_ack;
    logic [`MT_DATA_BITS-1:0] rdata;
    logic [`MT_AUX_BITS-1:0]  rd_aux;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`MT_ADDR_BITS-1:0] addr;
    logic [`MT_DATA_BITS-1:0] wdata;
    logic [`MT_SEL_BITS-1:0]  sel;
    logic [`MT_AUX_BITS-1:0]  aux;
    logic [`MT_CNT_BITS-1:0]  correct;
    logic [`MT_CNT_BITS-1:0]  wrong;
    logic [`MT_CNT_BITS-1:0]  faults;
    logic [`MT_DATA_BITS-1:0] wrong_data;
    logic [`MT_DATA_BITS-1:0] exp_data;
    logic                     wrong_nz;

    ////////////////////////////////////////
    // scenario table
    ////////////////////////////////////////
    string row_name    [ROWS];
    int    row_passes  [ROWS];
    int    row_btn_req [ROWS];  // press after this many requests of the pass, -1 none
    int    row_btn_len [ROWS];  // cycles held
    int    row_btn_gap [ROWS];  // second press this many cycles after the first, 0 none
    bit    row_drop    [ROWS];  // calibration drops after the row
    int    row_correct [ROWS];
    int    row_wrong   [ROWS];
    int    row_faults  [ROWS];

    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          req_idx     = 0;  // accepted requests since calibration rose
    int          n_burst_wr  = 0;
    int          n_scr_wr    = 0;
    int          n_alt       = 0;
    int          n_rd        = 0;
    int          n_zero_wr   = 0;  // writes whose written bytes are all zero
    bit          data_checks = 1'b1;
    bit          prev_stalled = 1'b0;
    logic [156:0] prev_req;
    logic [`MT_DATA_BITS-1:0] fault_exp = '0;  // pattern of the faulted address
    logic [`MT_DATA_BITS-1:0] fault_bad = '0;  // same word, written lane zeroed
    logic [31:0] lfsr        = 32'h388f_9886;
    string       cur_test    = "reset";

    memtest_top u_dut (
        .i_clk(clk), .i_rst_n(rst_n), .i_calib_complete(calib), .i_btn(btn),
        .i_wb_stall(wb_stall), .i_wb_ack(wb_ack), .i_wb_data(rdata), .i_aux(rd_aux),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we), .o_wb_addr(addr),
        .o_wb_data(wdata), .o_wb_sel(sel), .o_aux(aux),
        .o_correct_count(correct), .o_wrong_count(wrong), .o_fault_count(faults),
        .o_wrong_data(wrong_data), .o_expected_data(exp_data), .o_wrong_nonzero(wrong_nz)
    );

    wb_mem_model u_mem (
        .i_clk(clk), .i_rst_n(rst_n), .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
        .i_wb_addr(addr), .i_wb_data(wdata), .i_wb_sel(sel), .i_aux(aux),
        .i_wb_stall(wb_stall), .o_wb_ack(wb_ack), .o_wb_data(rdata), .o_aux(rd_aux)
    );

    always #20 clk = ~clk;  // 40 ns period

    // 8-byte group per address, repeated over the word
    function automatic logic [`MT_DATA_BITS-1:0] expect_word(input logic [7:0] a);
        logic [63:0] g;
        g[7:0]   = a ^ 8'h3C;
        g[15:8]  = a ^ 8'h7E;
        g[23:16] = a | 8'hC7;
        g[31:24] = a & 8'h21;
        g[39:32] = a ^ 8'h5A;
        g[47:40] = a & 8'h33;
        g[55:48] = a | 8'h1A;
        g[63:56] = a ^ 8'hA5;
        return {(`MT_DATA_BITS / 64){g}};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, one bit per step
    endfunction

    task automatic check_value(input string name, input logic [159:0] expected,
                               input logic [159:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic add_row(input int idx, input string name, input int passes,
                           input int btn_req, input int btn_len, input int btn_gap,
                           input bit drop, input int ok, input int bad, input int flt);
        row_name[idx]    = name;
        row_passes[idx]  = passes;
        row_btn_req[idx] = btn_req;
        row_btn_len[idx] = btn_len;
        row_btn_gap[idx] = btn_gap;
        row_drop[idx]    = drop;
        row_correct[idx] = ok;
        row_wrong[idx]   = bad;
        row_faults[idx]  = flt;
    endtask

    task automatic press_button(input int len);
        @(posedge clk);
        #2 btn = 1'b1;
        repeat (len) @(posedge clk);
        #2 btn = 1'b0;
    endtask

    // stall high when both LFSR bits of the cycle are set
    always @(posedge clk) begin
        logic first;
        #2;
        first    = lfsr[0];
        lfsr     = lfsr_next(lfsr);
        wb_stall = first & lfsr[0];
        lfsr     = lfsr_next(lfsr);
    end

    ////////////////////////////////////////
    // bus monitor
    ////////////////////////////////////////
    always @(negedge clk) begin
        int p;
        logic [7:0] a;
        logic [7:0] i;
        logic [7:0] widx;
        logic [15:0] s;
        logic ew;
        logic [`MT_DATA_BITS-1:0] m;
        if (!calib) begin
            req_idx      = 0;
            prev_stalled = 1'b0;
        end else begin
            if (prev_stalled) check_value({cur_test, " stall_hold"}, prev_req,
                                          {wb_we, addr, sel, aux, wdata});
            prev_stalled = wb_stb && wb_stall;
            prev_req     = {wb_we, addr, sel, aux, wdata};
            if (wb_cyc && wb_stb && !wb_stall) begin
                p  = req_idx % PASS_REQS;
                s  = '1;
                ew = 1'b1;
                i  = 8'(p);
                if (p < 512) begin                   // two lanes per address
                    a = 8'(p / 2);
                    s = (p % 2 == 0) ? 16'h00ff : 16'hff00;
                    n_burst_wr++;
                end else if (p < 768) begin
                    a  = 8'(p - 512);
                    ew = 1'b0;
                    n_rd++;
                end else if (p < 1024) begin         // swapped halves of the index
                    i = 8'(p - 768);
                    a = {i[`MT_HALF_ADDR-1:0], i[7:`MT_HALF_ADDR]};
                    n_scr_wr++;
                end else if (p < 1280) begin
                    i  = 8'(p - 1024);
                    a  = {i[`MT_HALF_ADDR-1:0], i[7:`MT_HALF_ADDR]};
                    ew = 1'b0;
                    n_rd++;
                end else begin                       // write, then read the same address
                    a  = 8'((p - 1280) / 2);
                    ew = (p % 2 == 0);
                    n_alt++;
                end
                widx = (p >= 768 && p < 1024) ? i : a;
                check_value({cur_test, " request"}, {ew, a, s, ew ? 4'd2 : 4'd3},
                            {wb_we, addr, sel, aux});
                for (int b = 0; b < `MT_SEL_BITS; b++) m[b*8 +: 8] = {8{s[b]}};
                if (ew && data_checks) check_value({cur_test, " write_data"},
                                                   expect_word(widx) & m, wdata & m);
                if (ew && ((wdata & m) == '0)) begin  // pattern lanes are never all zero
                    n_zero_wr++;
                    fault_exp = expect_word(widx);
                    fault_bad = expect_word(widx) & ~m;
                end
                req_idx++;
            end
        end
    end

    // run limit from the total number of passes
    initial begin
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: test did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////
    // scenarios
    ////////////////////////////////////////
    initial begin
        int target;     // reads expected since calibration rose
        int start_idx;
        int start_bw;
        int start_sw;
        int start_alt;
        int start_rd;
        int start_zw;
        add_row(0, "clean_pass",      1, -1,  0,  0, 1'b0,  768, 0, 0);
        add_row(1, "request_pattern", 1, -1,  0,  0, 1'b0, 1536, 0, 0);
        add_row(2, "fault_inject",    1, 100, 4,  0, 1'b0, 2303, 1, 1);
        add_row(3, "debounce",        1, 300, 10, 20, 1'b1, 3070, 2, 2);
        add_row(4, "after_recal",     1, -1,  0,  0, 1'b0,  768, 0, 0);
        cycle_limit = 2000;
        for (int r = 0; r < ROWS; r++) cycle_limit += row_passes[r] * 1300 * 2;
        target = 0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #2 calib = 1'b1;
        for (int r = 0; r < ROWS; r++) begin
            @(negedge clk);
            cur_test    = row_name[r];
            data_checks = (row_btn_req[r] < 0);      // faulted writes carry zeros
            target     += PASS_READS * row_passes[r];
            start_idx   = req_idx;
            start_bw    = n_burst_wr;
            start_sw    = n_scr_wr;
            start_alt   = n_alt;
            start_rd    = n_rd;
            start_zw    = n_zero_wr;
            if (row_btn_req[r] >= 0) begin
                while (req_idx - start_idx < row_btn_req[r]) @(negedge clk);
                press_button(row_btn_len[r]);
                if (row_btn_gap[r] > 0) begin        // second press inside the hold
                    repeat (row_btn_gap[r] - row_btn_len[r]) @(posedge clk);
                    press_button(row_btn_len[r]);
                end
            end
            while (correct + wrong < 32'(target)) @(negedge clk);
            check_value({cur_test, " correct"}, row_correct[r], correct);
            check_value({cur_test, " wrong"}, row_wrong[r], wrong);
            check_value({cur_test, " faults"}, row_faults[r], faults);
            check_value({cur_test, " nonzero"}, row_wrong[r] != 0, wrong_nz);
            check_value({cur_test, " burst_writes"}, 512 * row_passes[r], n_burst_wr - start_bw);
            check_value({cur_test, " scramble_writes"}, 256 * row_passes[r], n_scr_wr - start_sw);
            check_value({cur_test, " alternate_reqs"}, 512 * row_passes[r], n_alt - start_alt);
            check_value({cur_test, " reads"}, 512 * row_passes[r], n_rd - start_rd);
            check_value({cur_test, " zeroed_writes"}, (row_btn_req[r] >= 0) ? 1 : 0,
                        n_zero_wr - start_zw);
            if (row_btn_req[r] >= 0) begin           // one 8-byte lane zeroed
                check_value({cur_test, " expected_word"}, fault_exp, exp_data);
                check_value({cur_test, " wrong_word"}, fault_bad, wrong_data);
            end
            if (row_drop[r]) begin
                @(posedge clk);
                #2 calib = 1'b0;
                repeat (2) @(posedge clk);
                @(negedge clk);
                check_value("calib_drop bus", 0, {wb_cyc, wb_stb, wb_we, sel, aux, addr, wdata});
                check_value("calib_drop counts", 0, {correct, wrong, faults, wrong_nz});
                check_value("calib_drop wrong_data", 0, wrong_data);
                check_value("calib_drop expected_data", 0, exp_data);
                @(posedge clk);
                #2 calib = 1'b1;
                target = 0;
            end
        end
        $display("checks: %0d  errors: %0d  cycles: %0d", checks, errors, cycle_count);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: bench/wb_mem_model.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module wb_mem_model (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_wb_cyc,
    input  logic                     i_wb_stb,
    input  logic                     i_wb_we,
    input  logic [`MT_ADDR_BITS-1:0] i_wb_addr,
    input  logic [`MT_DATA_BITS-1:0] i_wb_data,
    input  logic [`MT_SEL_BITS-1:0]  i_wb_sel,
    input  logic [`MT_AUX_BITS-1:0]  i_aux,
    input  logic                     i_wb_stall,  // random stall comes from the testbench
    output logic                     o_wb_ack,
    output logic [`MT_DATA_BITS-1:0] o_wb_data,
    output logic [`MT_AUX_BITS-1:0]  o_aux
);

    localparam int LATENCY = 2;                   // ack follows acceptance by 2 cycles
    localparam int WORDS   = 1 << `MT_ADDR_BITS;

    logic [`MT_DATA_BITS-1:0] mem       [WORDS];
    logic                     ack_pipe  [LATENCY];
    logic [`MT_DATA_BITS-1:0] data_pipe [LATENCY];
    logic [`MT_AUX_BITS-1:0]  aux_pipe  [LATENCY];
    logic                     ack_out  = 1'b0;
    logic [`MT_DATA_BITS-1:0] data_out = '0;
    logic [`MT_AUX_BITS-1:0]  aux_out  = '0;

    assign o_wb_ack  = ack_out;
    assign o_wb_data = data_out;
    assign o_aux     = aux_out;

    initial begin
        for (int a = 0; a < WORDS; a++) begin
            mem[a] = {(`MT_DATA_BITS / 8){8'(a) ^ 8'h5C}};  // fill differs for every address
        end
    end

    ////////////////////////////////////////
    // request side, sampled mid-cycle
    ////////////////////////////////////////
    always @(negedge i_clk) begin
        logic take;
        take = i_wb_cyc && i_wb_stb && !i_wb_stall;  // accepted at the coming edge
        for (int k = LATENCY - 1; k > 0; k--) begin
            ack_pipe[k]  = ack_pipe[k-1];
            data_pipe[k] = data_pipe[k-1];
            aux_pipe[k]  = aux_pipe[k-1];
        end
        ack_pipe[0]  = take && i_rst_n;
        aux_pipe[0]  = i_aux;                        // tag echoed with the ack
        data_pipe[0] = '0;
        if (take && i_wb_we) begin
            for (int b = 0; b < `MT_SEL_BITS; b++) begin
                if (i_wb_sel[b]) mem[i_wb_addr][b*8 +: 8] = i_wb_data[b*8 +: 8];
            end
        end else if (take) begin
            data_pipe[0] = mem[i_wb_addr];
        end
    end

    // response driven just after the edge
    always @(posedge i_clk) begin
        #2;
        ack_out  = ack_pipe[LATENCY-1] && i_rst_n;
        data_out = data_pipe[LATENCY-1];
        aux_out  = aux_pipe[LATENCY-1];
    end

endmodule

// File: include/memtest_params.svh
`ifndef MEMTEST_PARAMS_SVH
`define MEMTEST_PARAMS_SVH

////////////////////////////////////////
// bus widths
////////////////////////////////////////
`define MT_ADDR_BITS     8    // wishbone word address
`define MT_DATA_BITS     128  // data word
`define MT_SEL_BITS      16   // one select per byte
`define MT_LANE_BYTES    8    // bytes per masked burst write
`define MT_AUX_BITS      4    // request tag carried on aux

////////////////////////////////////////
// test control
////////////////////////////////////////
`define MT_HALF_ADDR     4    // split point for the scrambled address swap
`define MT_REST_CYCLES   16   // idle gap before each test loop
`define MT_BTN_HOLD_LOG2 6    // debounce hold is 2**n cycles
`define MT_CNT_BITS      32   // status counter width

`endif

// File: rtl/fault_button.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module fault_button (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_btn,
    output logic o_fault_pulse
);

    localparam int HB = `MT_BTN_HOLD_LOG2;

    logic          btn_hold;       // stretched press level
    logic          btn_hold_prev;  // for edge detect
    logic [HB:0]   hold_cnt;       // msb set after 2**HB cycles of hold

    assign o_fault_pulse = btn_hold & ~btn_hold_prev;  // one cycle per accepted press

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            btn_hold      <= 1'b0;
            btn_hold_prev <= 1'b0;
            hold_cnt      <= '0;
        end else begin
            btn_hold_prev <= btn_hold;
            if (i_btn && !btn_hold) begin
                btn_hold <= 1'b1;  // first high sample latches the hold
            end
            if (hold_cnt[HB]) begin
                btn_hold <= 1'b0;  // hold expired, ready for a new press
                hold_cnt <= '0;
            end else if (btn_hold) begin
                hold_cnt <= hold_cnt + 1'b1;
            end else begin
                hold_cnt <= '0;
            end
        end
    end

endmodule

// File: rtl/mem_req_if.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

// pipelined wishbone request side, stall and ack travel as plain ports
interface mem_req_if;

    logic                     cyc;   // bus cycle active
    logic                     stb;   // request valid
    logic                     we;    // 1 write, 0 read
    logic [`MT_ADDR_BITS-1:0] addr;  // word address
    logic [`MT_DATA_BITS-1:0] data;  // write data
    logic [`MT_SEL_BITS-1:0]  sel;   // byte enables
    logic [`MT_AUX_BITS-1:0]  aux;   // request tag

    // traffic generator side
    modport sequencer (
        output cyc, stb, we, addr, data, sel, aux
    );

    // memory port side
    modport port (
        input cyc, stb, we, addr, data, sel, aux
    );

endinterface

// File: rtl/memtest_pkg.sv
`include "memtest_params.svh"

package memtest_pkg;

    ////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        idle           = 4'd0,  // waiting for calibration, then first rest
        burst_write    = 4'd1,  // masked lane writes, address order
        burst_read     = 4'd2,  // reads in address order
        scramble_write = 4'd3,  // address halves swapped
        scramble_read  = 4'd4,
        alternate      = 4'd5,  // write then read of the same address
        rest           = 4'd6   // stb low before the next loop
    } test_state_e;

    // aux tag, echoed back with the acknowledge
    typedef enum logic [`MT_AUX_BITS-1:0] {
        tag_write = `MT_AUX_BITS'(2),
        tag_read  = `MT_AUX_BITS'(3)
    } req_tag_e;

    ////////////////////////////////////////
    // data pattern
    ////////////////////////////////////////
    // one 8-byte group from the address byte, repeated over the word
    function automatic logic [`MT_DATA_BITS-1:0] pattern_word(input logic [7:0] a);
        logic [63:0] group;
        group = {a ^ 8'hA5,   // byte 7
                 a | 8'h1A,   // byte 6
                 a & 8'h33,   // byte 5
                 a ^ 8'h5A,   // byte 4
                 a & 8'h21,   // byte 3
                 a | 8'hC7,   // byte 2
                 a ^ 8'h7E,   // byte 1
                 a ^ 8'h3C};  // byte 0
        return {(`MT_DATA_BITS / 64){group}};
    endfunction

endpackage

// File: rtl/memtest_top.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module memtest_top (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_calib_complete,  // memory ready
    input  logic                     i_btn,             // fault inject button
    // wishbone response
    input  logic                     i_wb_stall,
    input  logic                     i_wb_ack,
    input  logic [`MT_DATA_BITS-1:0] i_wb_data,
    input  logic [`MT_AUX_BITS-1:0]  i_aux,
    // wishbone request
    output logic                     o_wb_cyc,
    output logic                     o_wb_stb,
    output logic                     o_wb_we,
    output logic [`MT_ADDR_BITS-1:0] o_wb_addr,
    output logic [`MT_DATA_BITS-1:0] o_wb_data,
    output logic [`MT_SEL_BITS-1:0]  o_wb_sel,
    output logic [`MT_AUX_BITS-1:0]  o_aux,
    // status
    output logic [`MT_CNT_BITS-1:0]  o_correct_count,
    output logic [`MT_CNT_BITS-1:0]  o_wrong_count,
    output logic [`MT_CNT_BITS-1:0]  o_fault_count,
    output logic [`MT_DATA_BITS-1:0] o_wrong_data,
    output logic [`MT_DATA_BITS-1:0] o_expected_data,
    output logic                     o_wrong_nonzero
);

    logic fault_pulse;

    mem_req_if req_bus ();  // sequencer to wishbone port

    ////////////////////////////////////////
    // request port
    ////////////////////////////////////////
    assign o_wb_cyc  = req_bus.cyc;
    assign o_wb_stb  = req_bus.stb;
    assign o_wb_we   = req_bus.we;
    assign o_wb_addr = req_bus.addr;
    assign o_wb_data = req_bus.data;
    assign o_wb_sel  = req_bus.sel;
    assign o_aux     = req_bus.aux;

    traffic_sequencer u_sequencer (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_calib_complete (i_calib_complete),
        .i_wb_stall       (i_wb_stall),
        .i_fault_pulse    (fault_pulse),
        .m_req            (req_bus.sequencer),
        .o_fault_count    (o_fault_count)
    );

    read_checker u_checker (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_calib_complete (i_calib_complete),
        .i_wb_ack         (i_wb_ack),
        .i_wb_data        (i_wb_data),
        .i_aux            (i_aux),
        .o_correct_count  (o_correct_count),
        .o_wrong_count    (o_wrong_count),
        .o_wrong_data     (o_wrong_data),
        .o_expected_data  (o_expected_data),
        .o_wrong_nonzero  (o_wrong_nonzero)
    );

    fault_button u_fault_button (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_btn         (i_btn),
        .o_fault_pulse (fault_pulse)
    );

endmodule

// File: rtl/read_checker.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module read_checker (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_calib_complete,
    input  logic                     i_wb_ack,
    input  logic [`MT_DATA_BITS-1:0] i_wb_data,
    input  logic [`MT_AUX_BITS-1:0]  i_aux,
    output logic [`MT_CNT_BITS-1:0]  o_correct_count,
    output logic [`MT_CNT_BITS-1:0]  o_wrong_count,
    output logic [`MT_DATA_BITS-1:0] o_wrong_data,
    output logic [`MT_DATA_BITS-1:0] o_expected_data,
    output logic                     o_wrong_nonzero
);

    logic [`MT_ADDR_BITS-1:0] chk_cnt;      // read order counter, wraps at top address
    logic [`MT_DATA_BITS-1:0] expected;
    logic                     rd_ack;       // ack of a tagged read
    logic                     match;
    logic                     inc_correct;  // registered compare result
    logic                     inc_wrong;

    assign expected = memtest_pkg::pattern_word(chk_cnt[7:0]);
    assign rd_ack   = i_wb_ack && (i_aux == memtest_pkg::tag_read);  // write acks ignored
    assign match    = (i_wb_data == expected);

    assign o_wrong_nonzero = (o_wrong_count != '0);

    ////////////////////////////////////////
    // compare and count
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            chk_cnt         <= '0;
            inc_correct     <= 1'b0;
            inc_wrong       <= 1'b0;
            o_correct_count <= '0;
            o_wrong_count   <= '0;
        end else if (!i_calib_complete) begin
            chk_cnt         <= '0;
            inc_correct     <= 1'b0;
            inc_wrong       <= 1'b0;
            o_correct_count <= '0;
            o_wrong_count   <= '0;
        end else begin
            inc_correct <= rd_ack & match;   // ack + 1
            inc_wrong   <= rd_ack & ~match;
            if (rd_ack) begin
                chk_cnt <= chk_cnt + 1'b1;
            end
            if (inc_correct) begin           // ack + 2
                o_correct_count <= o_correct_count + 1'b1;
            end
            if (inc_wrong) begin
                o_wrong_count <= o_wrong_count + 1'b1;
            end
        end
    end

    // last mismatch, held until the next one
    always_ff @(posedge i_clk) begin
        if (!i_calib_complete) begin
            o_wrong_data    <= '0;
            o_expected_data <= '0;
        end else if (rd_ack && !match) begin
            o_wrong_data    <= i_wb_data;
            o_expected_data <= expected;
        end
    end

endmodule

// File: rtl/traffic_sequencer.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module traffic_sequencer (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_calib_complete,
    input  logic                    i_wb_stall,
    input  logic                    i_fault_pulse,
    mem_req_if.sequencer            m_req,
    output logic [`MT_CNT_BITS-1:0] o_fault_count
);

    localparam int ABITS     = `MT_ADDR_BITS;
    localparam int HALF      = `MT_HALF_ADDR;
    localparam int LANE_BITS = `MT_LANE_BYTES * 8;
    localparam int LANES     = `MT_SEL_BITS / `MT_LANE_BYTES;
    localparam int REST      = `MT_REST_CYCLES;
    localparam int RW        = $clog2(REST);
    localparam logic [RW-1:0] REST_LAST = RW'(REST - 1);
    localparam logic [`MT_SEL_BITS-1:0] LANE_MASK =
        {{(`MT_SEL_BITS - `MT_LANE_BYTES){1'b0}}, {`MT_LANE_BYTES{1'b1}}};

    memtest_pkg::test_state_e state;
    logic [RW-1:0]             rest_cnt;       // gap length counter
    logic [ABITS-1:0]          wr_addr;        // write address counter
    logic [ABITS-1:0]          rd_addr;        // read address counter
    logic [$clog2(LANES)-1:0]  lane_idx;       // current 8-byte lane of burst write
    logic                      fault_pending;  // pulse seen, not yet used by a write
    logic                      fault_take;
    logic                      fault_hit;      // this write carries the fault
    logic                      issue;          // state wants to send a request
    logic                      issue_we;
    logic                      load;           // request registers advance
    logic [ABITS-1:0]          issue_addr;
    logic [`MT_DATA_BITS-1:0]  issue_data;
    logic [`MT_SEL_BITS-1:0]   issue_sel;
    logic [`MT_DATA_BITS-1:0]  word;           // pattern for the write counter
    logic [ABITS-1:0]          wr_swap;        // halves swapped, row/bank step
    logic [ABITS-1:0]          rd_swap;

    assign word       = memtest_pkg::pattern_word(wr_addr[7:0]);
    assign wr_swap    = {wr_addr[HALF-1:0], wr_addr[ABITS-1:HALF]};
    assign rd_swap    = {rd_addr[HALF-1:0], rd_addr[ABITS-1:HALF]};
    assign fault_take = fault_pending | i_fault_pulse;
    assign load       = issue & ~i_wb_stall;  // held request is taken this cycle
    assign fault_hit  = load & issue_we & fault_take;

    ////////////////////////////////////////
    // next request
    ////////////////////////////////////////
    always_comb begin
        issue      = 1'b0;
        issue_we   = 1'b0;
        issue_addr = wr_addr;
        issue_sel  = '1;
        issue_data = word;
        case (state)
            memtest_pkg::burst_write: begin
                issue      = 1'b1;
                issue_we   = 1'b1;
                issue_sel  = LANE_MASK << (lane_idx * `MT_LANE_BYTES);  // one lane at a time
                issue_data = {`MT_SEL_BITS{8'haa}};  // filler in masked bytes
                issue_data[lane_idx*LANE_BITS +: LANE_BITS] =
                    word[lane_idx*LANE_BITS +: LANE_BITS];
            end
            memtest_pkg::burst_read: begin
                issue      = 1'b1;
                issue_addr = rd_addr;
            end
            memtest_pkg::scramble_write: begin
                issue      = 1'b1;
                issue_we   = 1'b1;
                issue_addr = wr_swap;
            end
            memtest_pkg::scramble_read: begin
                issue      = 1'b1;
                issue_addr = rd_swap;
            end
            memtest_pkg::alternate: begin
                issue    = 1'b1;
                issue_we = ~m_req.we;  // write, then read back the same address
            end
            default: begin
                issue = 1'b0;  // idle and rest send nothing
            end
        endcase
        if (fault_hit) begin
            if (state == memtest_pkg::burst_write) begin
                issue_data[lane_idx*LANE_BITS +: LANE_BITS] = '0;  // only the written lane
            end else begin
                issue_data = '0;
            end
        end
    end

    ////////////////////////////////////////
    // test control
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= memtest_pkg::idle;
            rest_cnt      <= '0;
            wr_addr       <= '0;
            rd_addr       <= '0;
            lane_idx      <= '0;
            fault_pending <= 1'b0;
            o_fault_count <= '0;
            m_req.cyc     <= 1'b0;
            m_req.stb     <= 1'b0;
            m_req.we      <= 1'b0;
            m_req.sel     <= '0;
            m_req.aux     <= '0;
        end else if (!i_calib_complete) begin  // calibration lost, start over
            state         <= memtest_pkg::idle;
            rest_cnt      <= '0;
            wr_addr       <= '0;
            rd_addr       <= '0;
            lane_idx      <= '0;
            fault_pending <= 1'b0;
            o_fault_count <= '0;
            m_req.cyc     <= 1'b0;
            m_req.stb     <= 1'b0;
            m_req.we      <= 1'b0;
            m_req.sel     <= '0;
            m_req.aux     <= '0;
        end else begin
            fault_pending <= fault_take & ~fault_hit;
            if (fault_hit) begin
                o_fault_count <= o_fault_count + 1'b1;
            end
            if (load) begin
                m_req.stb <= 1'b1;
                m_req.we  <= issue_we;
                m_req.sel <= issue_sel;
                m_req.aux <= issue_we ? memtest_pkg::tag_write : memtest_pkg::tag_read;
            end
            case (state)
                memtest_pkg::idle: begin
                    rest_cnt <= rest_cnt + 1'b1;
                    if (rest_cnt == REST_LAST) begin
                        rest_cnt  <= '0;
                        m_req.cyc <= 1'b1;  // cyc stays up from here on
                        state     <= memtest_pkg::burst_write;
                    end
                end
                memtest_pkg::burst_write: if (load) begin
                    lane_idx <= lane_idx + 1'b1;
                    if (lane_idx == LANES - 1) begin  // last lane, next address
                        wr_addr <= wr_addr + 1'b1;
                        if (wr_addr == '1) state <= memtest_pkg::burst_read;
                    end
                end
                memtest_pkg::burst_read: if (load) begin
                    rd_addr <= rd_addr + 1'b1;
                    if (rd_addr == '1) state <= memtest_pkg::scramble_write;
                end
                memtest_pkg::scramble_write: if (load) begin
                    wr_addr <= wr_addr + 1'b1;
                    if (wr_addr == '1) state <= memtest_pkg::scramble_read;
                end
                memtest_pkg::scramble_read: if (load) begin
                    rd_addr <= rd_addr + 1'b1;
                    if (rd_addr == '1) state <= memtest_pkg::alternate;
                end
                memtest_pkg::alternate: if (load && !issue_we) begin  // step after the read
                    wr_addr <= wr_addr + 1'b1;
                    if (wr_addr == '1) state <= memtest_pkg::rest;
                end
                memtest_pkg::rest: begin
                    if (!i_wb_stall) m_req.stb <= 1'b0;  // last read must be taken first
                    rest_cnt <= rest_cnt + 1'b1;
                    if (rest_cnt == REST_LAST) begin
                        rest_cnt <= '0;
                        state    <= memtest_pkg::burst_write;
                    end
                end
                default: state <= memtest_pkg::idle;
            endcase
        end
    end

    // address and write data payload
    always_ff @(posedge i_clk) begin
        if (!i_calib_complete) begin
            m_req.addr <= '0;
            m_req.data <= '0;
        end else if (load) begin
            m_req.addr <= issue_addr;
            m_req.data <= issue_data;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_memtest -f sim.f > build.log 2>&1 \
    && ./obj_dir/Vtb_memtest > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -qx '\*\* PASS \*\*' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: sim.f
+incdir+include
rtl/memtest_pkg.sv
rtl/mem_req_if.sv
rtl/traffic_sequencer.sv
rtl/read_checker.sv
rtl/fault_button.sv
rtl/memtest_top.sv
bench/wb_mem_model.sv
bench/tb_memtest.sv
